// File: Makefile
# Verilator build and run of the divide unit testbench.

VERILATOR ?= verilator
TOP       ?= div_unit_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= ALL TESTS PASSED

SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard include/*.svh logic/*.sv verification/*.sv)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes.
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: include/div_consts.svh
// ----------------------------------------
// divide unit constants
// width of the data path and of the leading-zero counts.
// ----------------------------------------
`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// operand, quotient and remainder width in bits.
`define DIV_WIDTH 32

// bits needed to hold a leading-zero count of one data word.
`define DIV_CLZ_WIDTH 5

`endif

// File: logic/clz.sv
// ----------------------------------------
// leading-zero counter
// zeros above the highest set bit of one word.
// ----------------------------------------
`timescale 1ns/1ps
`include "div_consts.svh"

module clz import div_pkg::*; (
    input  data_t clz_input,  // word to be scanned.
    output clz_t  clz         // number of zeros above the highest set bit.
);

    // the scan walks from bit 0 upward, so a higher set bit overrides any
    // lower one and the last match is the highest set bit.
    // an all-zero word keeps the default of all ones, which is the same
    // count as a word with only bit 0 set. the divider tells the two
    // apart by looking at bit 0 itself.
    always_comb begin
        clz = '1;  // default for a word with no bit set.
        for (int i = 0; i < `DIV_WIDTH; i++) begin
            if (clz_input[i]) begin
                clz = clz_t'(`DIV_WIDTH - 1 - i);  // zeros above bit i.
            end
        end
    end

endmodule

// File: logic/div_operand_if.sv
// ----------------------------------------
// divider operand bus
// start pulse and held operand magnitudes.
// ----------------------------------------
`timescale 1ns/1ps

interface div_operand_if import div_pkg::*; ();

    logic  start;     // one-cycle pulse that launches the divider.
    data_t dividend;  // unsigned magnitude of the dividend.
    data_t divisor;   // unsigned magnitude of the divisor.

    // the input side drives the bus and keeps the magnitudes steady
    // from the start pulse until the result has been delivered.
    modport prep (
        output start,
        output dividend,
        output divisor
    );

    // the divider only reads the bus.
    modport core (
        input start,
        input dividend,
        input divisor
    );

endinterface

// File: logic/div_operand_prep.sv
// ----------------------------------------
// divider input side
// takes a request, converts signed operands to magnitudes,
// records the result signs and holds them until the result is out.
// ----------------------------------------
`timescale 1ns/1ps
`include "div_consts.svh"

module div_operand_prep import div_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,         // request strobe from the execute stage.
    input  div_op_e     op,            // requested operation.
    input  data_t       a,             // dividend as given.
    input  data_t       b,             // divisor as given.
    input  logic        result_taken,  // the output side has delivered the result.
    output logic        busy,          // a request is in progress.
    output logic        quot_neg,      // the quotient must be negated.
    output logic        rem_neg,       // the remainder must be negated.
    output logic        want_rem,      // deliver the remainder and not the quotient.
    div_operand_if.prep core
);

    prep_state_e state;
    logic        accept;     // a request is taken in this cycle.
    logic        is_signed;  // the operation treats operands as two's complement.
    logic        a_neg;      // the dividend is a negative signed value.
    logic        b_neg;      // the divisor is a negative signed value.

    assign accept    = start & (state == prep_idle);  // requests while busy are dropped.
    assign is_signed = (op == op_div) | (op == op_rem);
    assign a_neg     = is_signed & a[`DIV_WIDTH-1];
    assign b_neg     = is_signed & b[`DIV_WIDTH-1];

    // idle, launch and wait sequence.
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= prep_idle;
        end else begin
            case (state)
                prep_idle: begin
                    if (accept) begin
                        state <= prep_launch;
                    end
                end
                prep_launch: begin
                    state <= prep_wait;  // the core sees its start in this cycle.
                end
                prep_wait: begin
                    if (result_taken) begin
                        state <= prep_idle;
                    end
                end
                default: begin
                    state <= prep_idle;
                end
            endcase
        end
    end

    // operand magnitudes and result signs are loaded once per request.
    // the most negative value maps onto itself, which reads correctly as
    // an unsigned magnitude.
    always_ff @(posedge clk) begin
        if (accept) begin
            core.dividend <= a_neg ? -a : a;
            core.divisor  <= b_neg ? -b : b;
            quot_neg      <= a_neg ^ b_neg;   // signs differ, so the quotient is negative.
            rem_neg       <= a_neg;           // the remainder follows the dividend.
            want_rem      <= op[1];           // bit 1 of the code selects the remainder.
        end
    end

    assign core.start = (state == prep_launch);  // one cycle after the accept edge.
    assign busy       = (state != prep_idle);

endmodule

// File: logic/div_pkg.sv
// ----------------------------------------
// divide unit package
// shared vector types and state encodings.
// ----------------------------------------
`include "div_consts.svh"

package div_pkg;

    typedef logic [`DIV_WIDTH-1:0]     data_t;  // operands, quotient and remainder.
    typedef logic [`DIV_CLZ_WIDTH-1:0] clz_t;   // a leading-zero count.

    // the codes follow the low two bits of the RISC-V funct3 field.
    // bit 1 selects the remainder and bit 0 marks an unsigned operation.
    typedef enum logic [1:0] {
        op_div  = 2'b00,  // signed quotient.
        op_divu = 2'b01,  // unsigned quotient.
        op_rem  = 2'b10,  // signed remainder.
        op_remu = 2'b11   // unsigned remainder.
    } div_op_e;

    // input side sequencing.
    typedef enum logic [1:0] {
        prep_idle   = 2'b00,  // waiting for a request.
        prep_launch = 2'b01,  // operands are registered and the core is started.
        prep_wait   = 2'b10   // holding operands until the result has gone out.
    } prep_state_e;

endpackage

// File: logic/div_quick_clz.sv
// ----------------------------------------
// quick leading-zero divider
// restoring division on unsigned magnitudes that retires
// one or more quotient bits per cycle.
// ----------------------------------------
`timescale 1ns/1ps
`include "div_consts.svh"

module div_quick_clz import div_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    div_operand_if.core ops,
    div_result_if.core  res
);

    logic                running;       // iteration is under way.
    logic                terminate;     // the partial remainder is below the divisor.
    logic                divisor_zero;  // the held divisor is zero.

    data_t               quot;          // quotient built up bit by bit.
    data_t               rem;           // partial remainder.

    clz_t                rem_clz;       // leading zeros of the partial remainder.
    clz_t                div_clz;       // leading zeros of the divisor.
    clz_t                div_clz_r;
    clz_t                clz_delta;     // distance between the two top set bits.

    data_t               div_norm;      // divisor shifted up until its top bit is set.
    data_t               b1;            // divisor aligned to the remainder's top bit.
    data_t               b2;            // half of b1.
    logic [`DIV_WIDTH:0] diff1;         // remainder minus b1 with a borrow bit on top.
    data_t               diff2;         // remainder minus b2.
    data_t               new_rem;

    data_t               q_bit1;        // quotient bit for a subtraction of b1.
    data_t               q_bit2;        // quotient bit for a subtraction of b2.
    data_t               new_quot;

    clz clz_rem (
        .clz_input (rem),
        .clz       (rem_clz)
    );

    clz clz_div (
        .clz_input (ops.divisor),
        .clz       (div_clz)
    );

    // the divisor is held steady by the input side, so its normalized form
    // is simply re-registered every cycle and is ready from the first step.
    always_ff @(posedge clk) begin
        div_clz_r <= div_clz;
        div_norm  <= ops.divisor << div_clz;
    end

    // a count of all ones with bit 0 clear can only come from a zero word.
    assign divisor_zero = (&div_clz) & ~ops.divisor[0];

    assign terminate = (rem < ops.divisor);

    // while the remainder is not below the divisor its top bit sits at or
    // above the divisor's, so the delta is a valid bit index.
    assign clz_delta = div_clz_r - rem_clz;

    always_comb begin
        q_bit1            = '0;
        q_bit1[clz_delta] = 1'b1;
    end
    assign q_bit2 = {1'b0, q_bit1[`DIV_WIDTH-1:1]};

    // try the aligned divisor first; if that borrows, half of it always fits.
    assign b1    = div_norm >> rem_clz;
    assign b2    = {1'b0, b1[`DIV_WIDTH-1:1]};
    assign diff1 = {1'b0, rem} - {1'b0, b1};
    assign diff2 = rem - b2;

    assign new_rem  = diff1[`DIV_WIDTH] ? diff2 : diff1[`DIV_WIDTH-1:0];
    assign new_quot = quot | (diff1[`DIV_WIDTH] ? q_bit2 : q_bit1);

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
        end else if (ops.start & ~divisor_zero) begin
            running <= 1'b1;
        end else if (terminate) begin
            running <= 1'b0;
        end
    end

    // a zero divisor finishes straight away; otherwise the pulse follows
    // the step that brought the remainder below the divisor.
    always_ff @(posedge clk) begin
        if (rst) begin
            res.complete <= 1'b0;
        end else begin
            res.complete <= (running & terminate) | (ops.start & divisor_zero);
        end
    end

    always_ff @(posedge clk) begin
        if (ops.start) begin
            quot          <= divisor_zero ? '1 : '0;  // all ones is the RISC-V answer.
            rem           <= ops.dividend;            // also the zero-divisor remainder.
            res.b_is_zero <= divisor_zero;
        end else if (running & ~terminate) begin
            quot <= new_quot;
            rem  <= new_rem;
        end
    end

    assign res.quotient  = quot;
    assign res.remainder = rem;

endmodule

// File: logic/div_result_format.sv
// ----------------------------------------
// divider output side
// restores signs, picks quotient or remainder and applies the
// divide-by-zero rule.
// ----------------------------------------
`timescale 1ns/1ps

module div_result_format import div_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    div_result_if.format  res,
    input  logic          quot_neg,  // negate the quotient magnitude.
    input  logic          rem_neg,   // negate the remainder magnitude.
    input  logic          want_rem,  // deliver the remainder.
    output logic          done,      // one-cycle pulse with the final result.
    output data_t         result     // signed or unsigned result, held until the next request.
);

    data_t quot_final;  // quotient with its sign restored.
    data_t rem_final;   // remainder with its sign restored.

    // a zero divisor always gives all ones, whatever the operand signs.
    // the overflow case of the most negative value over minus one needs
    // no special path, because the magnitude quotient is already the
    // most negative value and quot_neg is clear.
    assign quot_final = res.b_is_zero ? '1 :
                        quot_neg      ? -res.quotient : res.quotient;

    // with a zero divisor the remainder is the dividend magnitude, and the
    // dividend sign brings back the original dividend.
    assign rem_final = rem_neg ? -res.remainder : res.remainder;

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= res.complete;  // follows complete by one cycle.
        end
    end

    // the result register keeps its value until the next completion.
    always_ff @(posedge clk) begin
        if (res.complete) begin
            result <= want_rem ? rem_final : quot_final;
        end
    end

endmodule

// File: logic/div_result_if.sv
// ----------------------------------------
// divider result bus
// completion pulse with raw quotient and remainder.
// ----------------------------------------
`timescale 1ns/1ps

interface div_result_if import div_pkg::*; ();

    logic  complete;   // one-cycle pulse when the division has finished.
    data_t quotient;   // unsigned quotient magnitude.
    data_t remainder;  // unsigned remainder magnitude.
    logic  b_is_zero;  // the divisor of this division was zero.

    // the divider drives the bus and holds the values until the next start.
    modport core (
        output complete,
        output quotient,
        output remainder,
        output b_is_zero
    );

    // the output side samples the bus on complete.
    modport format (
        input complete,
        input quotient,
        input remainder,
        input b_is_zero
    );

endinterface

// File: logic/div_unit.sv
// ----------------------------------------
// integer divide unit
// input side, quick divider and output side for the
// four RISC-V divide operations.
// ----------------------------------------
`timescale 1ns/1ps

module div_unit import div_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    start,   // request strobe, ignored while busy.
    input  div_op_e op,      // operation of the request.
    input  data_t   a,       // dividend.
    input  data_t   b,       // divisor.
    output logic    busy,    // high from the cycle after the request until after done.
    output logic    done,    // one-cycle pulse when result is valid.
    output data_t   result   // quotient or remainder.
);

    logic quot_neg;  // sign fix for the quotient.
    logic rem_neg;   // sign fix for the remainder.
    logic want_rem;  // remainder selection.

    div_operand_if op_bus ();
    div_result_if  res_bus ();

    div_operand_prep i_prep (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .op           (op),
        .a            (a),
        .b            (b),
        .result_taken (done),  // the delivered result frees the input side.
        .busy         (busy),
        .quot_neg     (quot_neg),
        .rem_neg      (rem_neg),
        .want_rem     (want_rem),
        .core         (op_bus.prep)
    );

    div_quick_clz i_core (
        .clk (clk),
        .rst (rst),
        .ops (op_bus.core),
        .res (res_bus.core)
    );

    div_result_format i_format (
        .clk      (clk),
        .rst      (rst),
        .res      (res_bus.format),
        .quot_neg (quot_neg),
        .rem_neg  (rem_neg),
        .want_rem (want_rem),
        .done     (done),
        .result   (result)
    );

endmodule

// File: verification/div_unit_tb.sv
// ----------------------------------------
// divide unit testbench
// directed corner cases and random requests checked
// against a reference model of the RISC-V divide rules.
// ----------------------------------------
`timescale 1ns/1ps
`include "div_consts.svh"

module div_unit_tb import div_pkg::*; ();

    localparam data_t min_value  = {1'b1, {(`DIV_WIDTH-1){1'b0}}};  // most negative value.
    localparam int    wait_limit = 100;  // cycles allowed for one result.

    logic    clk;
    logic    rst;
    logic    start;
    div_op_e op;
    data_t   a;
    data_t   b;
    logic    busy;
    logic    done;
    data_t   result;

    data_t   exp_result;               // expected value of the request in flight.
    string   test_name;                // label of the request in flight.
    int      requests_sent = 0;        // counted by the stimulus process.
    int      results_seen  = 0;        // counted by the compare process.
    int      result_checks = 0;
    int      result_errors = 0;
    int      flow_checks   = 0;        // busy and done sequencing checks.
    int      flow_errors   = 0;
    integer  seed          = 32'hf366_276b;

    div_unit i_dut (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period.
    end

    // expected result by the RISC-V division rules.
    function automatic data_t div_ref(input div_op_e rop, input data_t ra, input data_t rb);
        logic signed [`DIV_WIDTH-1:0] sa;
        logic signed [`DIV_WIDTH-1:0] sb;
        data_t                        value;
        sa = ra;
        sb = rb;
        case (rop)
            op_divu: value = (rb == '0) ? '1 : ra / rb;
            op_remu: value = (rb == '0) ? ra : ra % rb;
            op_div: begin
                if (rb == '0) begin
                    value = '1;                      // quotient of a zero divisor.
                end else if (ra == min_value && rb == '1) begin
                    value = min_value;               // overflow wraps to itself.
                end else begin
                    value = data_t'(sa / sb);        // truncates toward zero.
                end
            end
            op_rem: begin
                if (rb == '0) begin
                    value = ra;
                end else if (ra == min_value && rb == '1) begin
                    value = '0;
                end else begin
                    value = data_t'(sa % sb);        // sign of the dividend.
                end
            end
            default: value = '0;
        endcase
        return value;
    endfunction

    // the result is compared at the falling edge of every done pulse.
    always @(negedge clk) begin
        if (done) begin
            result_checks++;
            if (results_seen != requests_sent - 1) begin
                result_errors++;
                $display("done pulsed with no request outstanding");
            end else if (result !== exp_result) begin
                result_errors++;
                $display("mismatch %s: expected %h, actual %h", test_name, exp_result, result);
            end
            results_seen = requests_sent;
        end
    end

    // one request from start to the cycle after done. with poke set, a second
    // start with other operands is pulsed while the unit is busy.
    task automatic run_request(input string name, input div_op_e req_op, input data_t req_a,
                               input data_t req_b, input bit poke);
        int cycles;
        bit seen;
        cycles     = 0;
        seen       = 1'b0;
        exp_result = div_ref(req_op, req_a, req_b);
        test_name  = name;
        requests_sent++;
        @(posedge clk);
        start <= 1'b1;
        op    <= req_op;
        a     <= req_a;
        b     <= req_b;
        while (!seen && cycles < wait_limit) begin
            @(posedge clk);
            if (poke && cycles == 1) begin
                start <= 1'b1;  // the unit is busy and drops this start.
                op    <= (req_op == op_div) ? op_remu : op_div;
                a     <= ~req_a;
                b     <= req_b ^ 32'h5a5a_0f0f;
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
            flow_checks++;
            if (!busy) begin
                flow_errors++;
                $display("busy was low before done in %s", name);
            end
            seen = done;
            cycles++;
        end
        if (!seen) begin
            flow_errors++;
            $display("no done within %0d cycles in %s", wait_limit, name);
        end
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        flow_checks++;
        if (busy || done) begin
            flow_errors++;
            $display("busy or done still high one cycle after done in %s", name);
        end
    endtask

    initial begin
        data_t rnd;
        data_t ra;
        data_t rb;
        rst   = 1'b1;
        start = 1'b0;
        op    = op_div;
        a     = '0;
        b     = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        flow_checks++;
        if (busy || done) begin
            flow_errors++;
            $display("busy or done high right after reset");
        end

        // unsigned directed pairs.
        run_request("divu equal", op_divu, 32'd12345, 32'd12345, 1'b0);
        run_request("remu equal", op_remu, 32'd12345, 32'd12345, 1'b0);
        run_request("divu small dividend", op_divu, 32'd7, 32'd100, 1'b0);
        run_request("remu small dividend", op_remu, 32'd7, 32'd100, 1'b0);
        run_request("divu by one", op_divu, 32'hdead_beef, 32'd1, 1'b0);
        run_request("remu by one", op_remu, 32'hdead_beef, 32'd1, 1'b0);
        run_request("divu all ones", op_divu, 32'hffff_ffff, 32'd10, 1'b0);
        run_request("remu all ones", op_remu, 32'hffff_ffff, 32'd10, 1'b0);

        // every sign combination of dividend and divisor.
        run_request("div pos pos", op_div, data_t'(100), data_t'(7), 1'b0);
        run_request("rem pos pos", op_rem, data_t'(100), data_t'(7), 1'b0);
        run_request("div neg pos", op_div, data_t'(-100), data_t'(7), 1'b0);
        run_request("rem neg pos", op_rem, data_t'(-100), data_t'(7), 1'b0);
        run_request("div pos neg", op_div, data_t'(100), data_t'(-7), 1'b0);
        run_request("rem pos neg", op_rem, data_t'(100), data_t'(-7), 1'b0);
        run_request("div neg neg", op_div, data_t'(-100), data_t'(-7), 1'b0);
        run_request("rem neg neg", op_rem, data_t'(-100), data_t'(-7), 1'b0);

        // zero divisor with a negative and a positive dividend.
        for (int k = 0; k < 4; k++) begin
            run_request($sformatf("zero divisor op %0d neg", k), div_op_e'(k[1:0]),
                        32'h8765_4321, '0, 1'b0);
            run_request($sformatf("zero divisor op %0d pos", k), div_op_e'(k[1:0]),
                        32'd77, '0, 1'b0);
        end

        // signed overflow.
        run_request("div overflow", op_div, min_value, '1, 1'b0);
        run_request("rem overflow", op_rem, min_value, '1, 1'b0);

        for (int i = 0; i < 300; i++) begin
            rnd = $random(seed);
            ra  = $random(seed);
            rb  = data_t'($random(seed)) >> rnd[4:0];  // spreads the divisor sizes.
            if (rnd[9:6] == 4'd0) begin
                rb = '0;
            end else if (rnd[9:6] == 4'd1) begin
                ra = min_value;
                rb = '1;
            end
            run_request($sformatf("random %0d", i), div_op_e'(rnd[11:10]), ra, rb, 1'b1);
        end

        $display("checks: %0d, errors: %0d", result_checks + flow_checks,
                 result_errors + flow_errors);
        if (result_errors + flow_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
logic/div_pkg.sv
logic/div_operand_if.sv
logic/div_result_if.sv
logic/clz.sv
logic/div_operand_prep.sv
logic/div_quick_clz.sv
logic/div_result_format.sv
logic/div_unit.sv
verification/div_unit_tb.sv
